//--- Makefile
TOOL       = verilator
TOP        = scalar_function_tb
FILELIST   = verilog.f
FLAGS      = --timing --assert -Wno-fatal --top-module $(TOP)
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = TEST RESULT: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST)

build:
	$(TOOL) --binary $(FLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/scalar_pkg.sv
`default_nettype none

package scalar_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Data, element and modulus width
  localparam int DATA_SIZE = 32;

  // Stream length and element counter width
  localparam int LENGTH_SIZE = 16;

  // Bit index of the serial multiplier
  localparam int MUL_COUNT_SIZE = $clog2(DATA_SIZE);

  //////////////////////////////////////////////////////////////////////
  // Opcodes and command
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [0:0] {
    OP_SUM     = 1'b0,  // Modular sum of the stream
    OP_PRODUCT = 1'b1   // Modular product of the stream
  } scalar_op_t;

  // Command captured on START, 49 bits
  typedef struct packed {
    scalar_op_t             op;
    logic [DATA_SIZE-1:0]   modulo;
    logic [LENGTH_SIZE-1:0] length;
  } scalar_cmd_t;

  //////////////////////////////////////////////////////////////////////
  // FSM states
  //////////////////////////////////////////////////////////////////////

  // Decoder
  typedef enum logic [0:0] {
    DEC_IDLE   = 1'b0,  // Waiting for START
    DEC_STREAM = 1'b1   // Taking elements
  } decode_state_t;

  // Execute stage
  typedef enum logic [1:0] {
    CORE_IDLE = 2'd0,
    CORE_ADD  = 2'd1,
    CORE_MUL  = 2'd2
  } core_state_t;

  // Serial multiplier
  typedef enum logic [0:0] {
    MUL_IDLE = 1'b0,
    MUL_RUN  = 1'b1
  } mult_state_t;

endpackage

`default_nettype wire

//--- design/scalar_decoder.sv
`default_nettype none

module scalar_decoder (
  input  wire                                CLK,
  input  wire                                RST,
  input  wire                                START,
  input  wire scalar_pkg::scalar_op_t        OPCODE_IN,
  input  wire [scalar_pkg::DATA_SIZE-1:0]    MODULO_IN,
  input  wire [scalar_pkg::LENGTH_SIZE-1:0]  LENGTH_IN,
  input  wire                                DATA_IN_ENABLE,
  input  wire [scalar_pkg::DATA_SIZE-1:0]    DATA_IN,
  input  wire                                busy,
  output scalar_pkg::scalar_cmd_t            cmd,
  output logic                               cmd_load,
  output logic                               elem_valid,
  output logic [scalar_pkg::DATA_SIZE-1:0]   elem_data,
  output logic                               elem_last
);

  import scalar_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  decode_state_t          state;
  logic [LENGTH_SIZE-1:0] elem_count;
  logic                   take_cmd;
  logic                   take_elem;
  logic                   elem_is_last;

  // Core idle and no element in flight
  assign take_cmd  = (state == DEC_IDLE) && START && !busy && !elem_valid;
  assign take_elem = (state == DEC_STREAM) && DATA_IN_ENABLE && !busy && !elem_valid;

  // Index equals length minus one
  assign elem_is_last = (elem_count == cmd.length - 1'b1);

  //////////////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= DEC_IDLE;
      cmd_load   <= 1'b0;
      elem_valid <= 1'b0;
      elem_count <= '0;
    end else begin
      // Single cycle strobes
      cmd_load   <= 1'b0;
      elem_valid <= 1'b0;
      case (state)
        DEC_IDLE: begin
          if (take_cmd) begin
            cmd_load   <= 1'b1;
            elem_count <= '0;
            state      <= DEC_STREAM;
          end
        end
        DEC_STREAM: begin
          if (take_elem) begin
            elem_valid <= 1'b1;
            elem_count <= elem_count + 1'b1;
            // Back to idle as the final element goes out
            if (elem_is_last) begin
              state <= DEC_IDLE;
            end
          end
        end
        default: state <= DEC_IDLE;
      endcase
    end
  end

  // Command and element payload
  always_ff @(posedge CLK) begin
    if (take_cmd) begin
      cmd <= '{op: OPCODE_IN, modulo: MODULO_IN, length: LENGTH_IN};
    end
    if (take_elem) begin
      elem_data <= DATA_IN;
      elem_last <= elem_is_last;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // Stray START, dropped
  start_ignored: assert property (@(posedge CLK) disable iff (RST)
    START |-> take_cmd)
    else $warning("START ignored, command running or core busy");

  // Stray element strobe, dropped
  enable_ignored: assert property (@(posedge CLK) disable iff (RST)
    DATA_IN_ENABLE |-> take_elem)
    else $warning("DATA_IN_ENABLE ignored, no stream open or core busy");

  // Command operands
  cmd_legal: assert property (@(posedge CLK) disable iff (RST)
    take_cmd |-> (LENGTH_IN != '0) && (MODULO_IN > DATA_SIZE'(1)))
    else $error("Zero length or modulus below two");

endmodule

`default_nettype wire

//--- design/scalar_function_top.sv
`default_nettype none

module scalar_function_top (
  input  wire                                CLK,
  input  wire                                RST,
  input  wire                                START,
  input  wire scalar_pkg::scalar_op_t        OPCODE_IN,
  input  wire [scalar_pkg::DATA_SIZE-1:0]    MODULO_IN,
  input  wire [scalar_pkg::LENGTH_SIZE-1:0]  LENGTH_IN,
  input  wire                                DATA_IN_ENABLE,
  input  wire [scalar_pkg::DATA_SIZE-1:0]    DATA_IN,
  output wire                                BUSY,
  output wire                                DATA_OUT_ENABLE,
  output wire                                READY,
  output wire [scalar_pkg::DATA_SIZE-1:0]    DATA_OUT
);

  import scalar_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Stage wiring
  //////////////////////////////////////////////////////////////////////

  // Decode to execute
  scalar_cmd_t          cmd;
  logic                 cmd_load;
  logic                 elem_valid;
  logic [DATA_SIZE-1:0] elem_data;
  logic                 elem_last;

  // Execute to result
  logic                 acc_done;
  logic [DATA_SIZE-1:0] acc_value;

  scalar_decoder u_decoder (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .OPCODE_IN      (OPCODE_IN),
    .MODULO_IN      (MODULO_IN),
    .LENGTH_IN      (LENGTH_IN),
    .DATA_IN_ENABLE (DATA_IN_ENABLE),
    .DATA_IN        (DATA_IN),
    .busy           (BUSY),
    .cmd            (cmd),
    .cmd_load       (cmd_load),
    .elem_valid     (elem_valid),
    .elem_data      (elem_data),
    .elem_last      (elem_last)
  );

  // BUSY doubles as the element gate
  scalar_reduction_core u_core (
    .CLK        (CLK),
    .RST        (RST),
    .cmd        (cmd),
    .cmd_load   (cmd_load),
    .elem_valid (elem_valid),
    .elem_data  (elem_data),
    .elem_last  (elem_last),
    .busy       (BUSY),
    .acc_done   (acc_done),
    .acc_value  (acc_value)
  );

  scalar_result u_result (
    .CLK             (CLK),
    .RST             (RST),
    .acc_done        (acc_done),
    .acc_value       (acc_value),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .READY           (READY),
    .DATA_OUT        (DATA_OUT)
  );

endmodule

`default_nettype wire

//--- design/scalar_reduction_core.sv
`default_nettype none

module scalar_reduction_core (
  input  wire                               CLK,
  input  wire                               RST,
  input  wire scalar_pkg::scalar_cmd_t      cmd,
  input  wire                               cmd_load,
  input  wire                               elem_valid,
  input  wire [scalar_pkg::DATA_SIZE-1:0]   elem_data,
  input  wire                               elem_last,
  output logic                              busy,
  output logic                              acc_done,
  output logic [scalar_pkg::DATA_SIZE-1:0]  acc_value
);

  import scalar_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  core_state_t          state;
  scalar_op_t           op_reg;
  logic [DATA_SIZE-1:0] modulo;
  logic [DATA_SIZE-1:0] elem_reg;
  logic                 last_reg;

  // Modular add, one bit of headroom
  logic [DATA_SIZE:0]   sum_wide;
  logic [DATA_SIZE:0]   sum_diff;
  logic [DATA_SIZE-1:0] sum_mod;

  // Multiplier side
  logic                 mul_start;
  logic [DATA_SIZE-1:0] mul_a;
  logic [DATA_SIZE-1:0] mul_b;
  logic [DATA_SIZE-1:0] mul_mod;
  logic                 mul_done;
  logic [DATA_SIZE-1:0] mul_out;

  // Busy while an element is being folded in
  assign busy = (state != CORE_IDLE);

  assign sum_wide = {1'b0, acc_value} + {1'b0, elem_reg};
  assign sum_diff = sum_wide - {1'b0, modulo};
  assign sum_mod  = (sum_wide >= {1'b0, modulo}) ? sum_diff[DATA_SIZE-1:0]
                                                  : sum_wide[DATA_SIZE-1:0];

  // Product launches straight off the element strobe
  assign mul_start = elem_valid && (state == CORE_IDLE) && (op_reg == OP_PRODUCT);
  assign mul_a     = acc_value;
  assign mul_b     = elem_data;
  assign mul_mod   = modulo;

  //////////////////////////////////////////////////////////////////////
  // Execute FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= CORE_IDLE;
      op_reg    <= OP_SUM;
      acc_value <= '0;
      last_reg  <= 1'b0;
      acc_done  <= 1'b0;
    end else begin
      acc_done <= 1'b0;
      case (state)
        CORE_IDLE: begin
          if (cmd_load) begin
            // Identity of the operation
            op_reg    <= cmd.op;
            acc_value <= (cmd.op == OP_PRODUCT) ? DATA_SIZE'(1) : '0;
          end else if (elem_valid) begin
            last_reg <= elem_last;
            state    <= (op_reg == OP_PRODUCT) ? CORE_MUL : CORE_ADD;
          end
        end
        CORE_ADD: begin
          acc_value <= sum_mod;
          acc_done  <= last_reg;
          state     <= CORE_IDLE;
        end
        CORE_MUL: begin
          // Wait out the serial product
          if (mul_done) begin
            acc_value <= mul_out;
            acc_done  <= last_reg;
            state     <= CORE_IDLE;
          end
        end
        default: state <= CORE_IDLE;
      endcase
    end
  end

  // Modulus and operand
  always_ff @(posedge CLK) begin
    if ((state == CORE_IDLE) && cmd_load) begin
      modulo <= cmd.modulo;
    end
    if ((state == CORE_IDLE) && elem_valid) begin
      elem_reg <= elem_data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Modular multiplier
  //////////////////////////////////////////////////////////////////////

  scalar_multiplier u_multiplier (
    .CLK       (CLK),
    .RST       (RST),
    .START     (mul_start),
    .MODULO_IN (mul_mod),
    .DATA_A_IN (mul_a),
    .DATA_B_IN (mul_b),
    .READY     (mul_done),
    .DATA_OUT  (mul_out)
  );

  // Elements arrive already reduced
  elem_below_mod: assert property (@(posedge CLK) disable iff (RST)
    elem_valid |-> (elem_data < modulo))
    else $error("Element not below the modulus");

  // Fixed product latency, load plus one cycle per bit
  mul_latency: assert property (@(posedge CLK) disable iff (RST)
    mul_start |-> ##(DATA_SIZE + 1) mul_done)
    else $error("Multiplier latency mismatch");

endmodule

`default_nettype wire

//--- design/scalar_result.sv
`default_nettype none

module scalar_result (
  input  wire                               CLK,
  input  wire                               RST,
  input  wire                               acc_done,
  input  wire [scalar_pkg::DATA_SIZE-1:0]   acc_value,
  output logic                              DATA_OUT_ENABLE,
  output logic                              READY,
  output logic [scalar_pkg::DATA_SIZE-1:0]  DATA_OUT
);

  import scalar_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Result register and strobes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      DATA_OUT_ENABLE <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT        <= '0;
    end else begin
      // Both strobes last one cycle
      DATA_OUT_ENABLE <= acc_done;
      READY           <= acc_done;
      // Held until the next result
      if (acc_done) begin
        DATA_OUT <= acc_value;
      end
    end
  end

  // Results are separated by at least one element
  no_double_strobe: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_ENABLE |=> !DATA_OUT_ENABLE)
    else $error("DATA_OUT_ENABLE fired twice in a row");

endmodule

`default_nettype wire

//--- scalar_multiplier/scalar_multiplier.sv
`default_nettype none

module scalar_multiplier (
  input  wire                               CLK,
  input  wire                               RST,
  input  wire                               START,
  input  wire [scalar_pkg::DATA_SIZE-1:0]   MODULO_IN,
  input  wire [scalar_pkg::DATA_SIZE-1:0]   DATA_A_IN,
  input  wire [scalar_pkg::DATA_SIZE-1:0]   DATA_B_IN,
  output logic                              READY,
  output logic [scalar_pkg::DATA_SIZE-1:0]  DATA_OUT
);

  import scalar_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  mult_state_t               state;
  logic [MUL_COUNT_SIZE-1:0] bit_count;
  logic                      last_bit;

  // Operands, B shifts out MSB first
  logic [DATA_SIZE-1:0] modulo;
  logic [DATA_SIZE-1:0] data_a;
  logic [DATA_SIZE-1:0] data_b;
  logic [DATA_SIZE-1:0] partial;

  // One step of the interleaved reduction
  logic [DATA_SIZE:0]   dbl_wide;
  logic [DATA_SIZE:0]   dbl_diff;
  logic [DATA_SIZE-1:0] dbl_mod;
  logic [DATA_SIZE:0]   add_wide;
  logic [DATA_SIZE:0]   add_diff;
  logic [DATA_SIZE-1:0] add_mod;
  logic [DATA_SIZE-1:0] partial_next;

  assign last_bit = (bit_count == '0);

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // 2p mod m, one subtract is enough as p < m
    dbl_wide = {partial, 1'b0};
    dbl_diff = dbl_wide - {1'b0, modulo};
    dbl_mod  = (dbl_wide >= {1'b0, modulo}) ? dbl_diff[DATA_SIZE-1:0]
                                             : dbl_wide[DATA_SIZE-1:0];
    // Then + a mod m, a already reduced
    add_wide = {1'b0, dbl_mod} + {1'b0, data_a};
    add_diff = add_wide - {1'b0, modulo};
    add_mod  = (add_wide >= {1'b0, modulo}) ? add_diff[DATA_SIZE-1:0]
                                             : add_wide[DATA_SIZE-1:0];
    // Current bit of B selects
    partial_next = data_b[DATA_SIZE-1] ? add_mod : dbl_mod;
  end

  always_ff @(posedge CLK) begin
    if ((state == MUL_IDLE) && START) begin
      modulo  <= MODULO_IN;
      data_a  <= DATA_A_IN;
      data_b  <= DATA_B_IN;
      partial <= '0;
    end else if (state == MUL_RUN) begin
      partial <= partial_next;
      data_b  <= {data_b[DATA_SIZE-2:0], 1'b0};
      if (last_bit) begin
        DATA_OUT <= partial_next;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= MUL_IDLE;
      bit_count <= '0;
      READY     <= 1'b0;
    end else begin
      READY <= 1'b0;
      case (state)
        MUL_IDLE: begin
          if (START) begin
            bit_count <= MUL_COUNT_SIZE'(DATA_SIZE - 1);
            state     <= MUL_RUN;
          end
        end
        MUL_RUN: begin
          bit_count <= bit_count - 1'b1;
          // LSB of B done
          if (last_bit) begin
            READY <= 1'b1;
            state <= MUL_IDLE;
          end
        end
        default: state <= MUL_IDLE;
      endcase
    end
  end

  // No restart mid-product
  start_while_run: assert property (@(posedge CLK) disable iff (RST)
    START |-> (state == MUL_IDLE))
    else $error("Multiplier started while running");

endmodule

`default_nettype wire

//--- verif/scalar_function_tb.sv
`default_nettype none

module scalar_function_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import scalar_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Run setup
  //////////////////////////////////////////////////////////////////////

  localparam int NUM_CMDS     = 40;
  localparam int MAX_LEN      = 8;
  localparam int CLK_HALF     = 20;
  localparam int RESET_CYCLES = 5;
  // Every command at full length, every element a product
  localparam int TIMEOUT_CYCLES = NUM_CMDS * MAX_LEN * (DATA_SIZE + 4) + 4000;
  // Last element to strobe, product worst case
  localparam int RESULT_WAIT = 2 * (DATA_SIZE + 4);

  logic                   CLK = 1'b0;
  logic                   RST;
  logic                   start;
  scalar_op_t             opcode;
  logic [DATA_SIZE-1:0]   modulo;
  logic [LENGTH_SIZE-1:0] length;
  logic                   data_in_enable;
  logic [DATA_SIZE-1:0]   data_in;
  logic                   busy;
  logic                   data_out_enable;
  logic                   ready;
  logic [DATA_SIZE-1:0]   data_out;

  // Checker state
  logic [31:0]          lfsr_state;
  logic [DATA_SIZE-1:0] elems [MAX_LEN];
  logic [DATA_SIZE-1:0] prev_data_out = '0;
  bit                   result_expected = 1'b0;
  int                   mismatch_count = 0;
  int                   error_count = 0;
  int                   result_count = 0;
  int                   wrap_count = 0;
  int                   cycle_count = 0;

  always #CLK_HALF CLK = ~CLK;

  scalar_function_top UUT (
    .CLK             (CLK),
    .RST             (RST),
    .START           (start),
    .OPCODE_IN       (opcode),
    .MODULO_IN       (modulo),
    .LENGTH_IN       (length),
    .DATA_IN_ENABLE  (data_in_enable),
    .DATA_IN         (data_in),
    .BUSY            (busy),
    .DATA_OUT_ENABLE (data_out_enable),
    .READY           (ready),
    .DATA_OUT        (data_out)
  );

  //////////////////////////////////////////////////////////////////////
  // Random source and reference model
  //////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic feedback;
    feedback = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], feedback};
  endfunction

  // One step per bit, LSB last
  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // Wide fold, reduced after every element
  function automatic logic [63:0] model_fold(input scalar_op_t op, input logic [63:0] m,
                                             input int len);
    logic [63:0] acc;
    acc = (op == OP_PRODUCT) ? 64'd1 : 64'd0;
    for (int i = 0; i < len; i++) begin
      if (op == OP_PRODUCT) begin
        acc = (acc * {32'd0, elems[i]}) % m;
      end else begin
        acc = acc + {32'd0, elems[i]};
        // Sum went past the modulus
        if (acc >= m) begin
          wrap_count++;
        end
        acc = acc % m;
      end
    end
    return acc;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus and checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_reset_state();
    if (busy !== 1'b0) begin
      mismatch_count++;
      $display("MISMATCH at %0t: BUSY is %b in reset state, expected 0", $time, busy);
    end
    if (data_out_enable !== 1'b0 || ready !== 1'b0) begin
      mismatch_count++;
      $display("MISMATCH at %0t: DATA_OUT_ENABLE %b READY %b, expected 0 0",
               $time, data_out_enable, ready);
    end
    if (data_out !== '0) begin
      mismatch_count++;
      $display("MISMATCH at %0t: DATA_OUT is %h after reset, expected 0", $time, data_out);
    end
  endtask

  // Core idle, sampled mid-cycle
  task automatic wait_idle();
    @(negedge CLK);
    while (busy) begin
      @(negedge CLK);
    end
  endtask

  task automatic send_command(input scalar_op_t op, input logic [DATA_SIZE-1:0] m,
                              input logic [LENGTH_SIZE-1:0] len);
    @(posedge CLK);
    start  <= 1'b1;
    opcode <= op;
    modulo <= m;
    length <= len;
    @(posedge CLK);
    start <= 1'b0;
  endtask

  task automatic send_element(input logic [DATA_SIZE-1:0] value, input bit last);
    wait_idle();
    @(posedge CLK);
    data_in_enable <= 1'b1;
    data_in        <= value;
    if (last) begin
      result_expected = 1'b1;
    end
    @(posedge CLK);
    data_in_enable <= 1'b0;
    // BUSY rises one cycle after the decoder takes it
    @(posedge CLK);
  endtask

  // Ignored START with junk operands
  task automatic pulse_stray_start();
    logic [31:0] r;
    r = random_bits(1);
    @(posedge CLK);
    start  <= 1'b1;
    opcode <= r[0] ? OP_PRODUCT : OP_SUM;
    modulo <= random_bits(32);
    length <= LENGTH_SIZE'(random_bits(4));
    @(posedge CLK);
    start <= 1'b0;
  endtask

  task automatic wait_result(input int cmd_index, input logic [63:0] expected,
                             input bit single_elem, input logic [DATA_SIZE-1:0] first_elem);
    int waited;
    waited = 0;
    @(negedge CLK);
    while (!data_out_enable && waited < RESULT_WAIT) begin
      @(negedge CLK);
      waited++;
    end
    if (!data_out_enable) begin
      error_count++;
      $display("Command %0d gave no DATA_OUT_ENABLE within %0d cycles", cmd_index, RESULT_WAIT);
    end else if (single_elem) begin
      // Identity start, the lone element comes back as is
      if (data_out != first_elem) begin
        mismatch_count++;
        $display("MISMATCH at %0t: command %0d single element %h came back as %h",
                 $time, cmd_index, first_elem, data_out);
      end
    end else if ({32'd0, data_out} != expected) begin
      mismatch_count++;
      $display("MISMATCH at %0t: command %0d result %h, expected %h",
               $time, cmd_index, data_out, expected[31:0]);
    end
    // Any further strobe is a repeat
    @(posedge CLK);
    result_expected = 1'b0;
  endtask

  // Strobe pairing, placement and DATA_OUT hold
  always @(negedge CLK) begin
    if (!RST) begin
      if (ready != data_out_enable) begin
        error_count++;
        $display("READY and DATA_OUT_ENABLE differ at %0t", $time);
      end
      if (data_out_enable) begin
        result_count++;
        if (!result_expected) begin
          error_count++;
          $display("DATA_OUT_ENABLE at %0t with no finished stream waiting", $time);
        end
      end
      if (!data_out_enable && data_out != prev_data_out) begin
        error_count++;
        $display("DATA_OUT changed at %0t without DATA_OUT_ENABLE", $time);
      end
    end
    prev_data_out = data_out;
  end

  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout, run still going after %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    scalar_op_t           op;
    logic [DATA_SIZE-1:0] m;
    logic [31:0]          r;
    logic [63:0]          expected;
    int                   len;
    int                   stray_at;

    lfsr_state     = 32'h8176_614e;
    RST            = 1'b1;
    start          = 1'b0;
    opcode         = OP_SUM;
    modulo         = '0;
    length         = '0;
    data_in_enable = 1'b0;
    data_in        = '0;

    @(negedge CLK);
    check_reset_state();
    repeat (RESET_CYCLES) @(posedge CLK);
    RST <= 1'b0;
    @(negedge CLK);
    check_reset_state();

    for (int c = 0; c < NUM_CMDS; c++) begin
      r  = random_bits(1);
      op = r[0] ? OP_PRODUCT : OP_SUM;
      // Single element, once per opcode
      if (c < 2) begin
        op  = (c == 0) ? OP_SUM : OP_PRODUCT;
        len = 1;
      end else begin
        len = int'(random_bits(3)) + 1;
      end

      // Small, near-max or full-range modulus
      r = random_bits(2);
      if (r[1:0] == 2'd0) begin
        m = random_bits(8);
      end else if (r[1:0] == 2'd1) begin
        m = 32'hFFFF_FFFF - random_bits(4);
      end else begin
        m = random_bits(32);
      end
      if (m < 32'd2) begin
        m = m + 32'd2;
      end

      for (int i = 0; i < len; i++) begin
        elems[i] = random_bits(32) % m;
      end
      expected = model_fold(op, {32'd0, m}, len);

      // Extra START somewhere mid-stream, zero for none
      r        = random_bits(1);
      stray_at = (r[0] && len > 1) ? (int'(random_bits(3)) % (len - 1)) + 1 : 0;

      send_command(op, m, LENGTH_SIZE'(len));
      for (int i = 0; i < len; i++) begin
        if (stray_at != 0 && i == stray_at) begin
          pulse_stray_start();
        end
        send_element(elems[i], i == len - 1);
      end
      wait_result(c, expected, len == 1, elems[0]);
    end

    // Room for a late extra strobe
    repeat (4) @(negedge CLK);
    if (result_count != NUM_CMDS) begin
      error_count++;
      $display("Saw %0d results for %0d commands", result_count, NUM_CMDS);
    end
    if (wrap_count == 0) begin
      error_count++;
      $display("No modular sum wrapped past its modulus");
    end

    $display("Done: %0d mismatches, %0d other errors, %0d results, %0d sum wraps",
             mismatch_count, error_count, result_count, wrap_count);
    if (mismatch_count == 0 && error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
common/scalar_pkg.sv
scalar_multiplier/scalar_multiplier.sv
design/scalar_decoder.sv
design/scalar_reduction_core.sv
design/scalar_result.sv
design/scalar_function_top.sv
verif/scalar_function_tb.sv
